//--- source/dmem_pkg.sv
package dmem_pkg;

    // Data path and address width
    localparam int xlen = 32;

    // One lane per byte of the word
    localparam int lanes = xlen / 8;

    // Words held in each bank
    localparam int depth = 256;

    // Word index taken from addr[9:2]
    localparam int word_addr_bits = $clog2(depth);

    // Access width code, same layout as the core's width_src
    // Bits 1:0 give the size, bit 2 marks an unsigned load
    typedef enum logic [2:0] {
        width_word   = 3'b000, // lw / sw
        width_byte   = 3'b001, // lb / sb
        width_half   = 3'b010, // lh / sh
        width_byte_u = 3'b101, // lbu
        width_half_u = 3'b110  // lhu
    } mem_width_e;

    // Remaining codes (011, 100, 111) are reserved
    // Stores with them touch no lane, loads with them return zero

endpackage

//--- source/store_align.sv
`timescale 1ns/10ps

module store_align (
    input  logic                                we,
    input  dmem_pkg::mem_width_e                width_src,
    input  logic [dmem_pkg::xlen-1:0]           addr,
    input  logic [dmem_pkg::xlen-1:0]           wdata,
    input  logic                                rst_n,
    output logic [dmem_pkg::lanes-1:0]          lane_we,
    output logic [dmem_pkg::lanes-1:0][7:0]     lane_wdata,
    output logic [dmem_pkg::word_addr_bits-1:0] word_idx
);

    import dmem_pkg::*;

    logic [1:0]       byte_off;  // Lane within the word
    logic [lanes-1:0] size_mask; // Lanes the access covers, before gating
    logic             wr_ok;     // Write allowed this cycle

    // Byte offset and word index straight from the address
    // Bits above the index are dropped, so the memory wraps
    assign byte_off = addr[1:0];
    assign word_idx = addr[word_addr_bits+1:2];

    // Lane mask and lane data per access size
    always_comb begin
        size_mask  = '0;
        lane_wdata = wdata; // Word layout by default

        case (width_src)
            // Full word, every lane
            width_word: begin
                size_mask = 4'b1111;
            end

            // Half-word, addr[0] ignored
            width_half,
            width_half_u: begin
                if (byte_off[1]) begin
                    size_mask = 4'b1100; // Upper half
                end else begin
                    size_mask = 4'b0011; // Lower half
                end
                lane_wdata = {2{wdata[15:0]}}; // Low half on both pairs
            end

            // Single byte on the addressed lane
            width_byte,
            width_byte_u: begin
                size_mask  = 4'b0001 << byte_off;
                lane_wdata = {lanes{wdata[7:0]}}; // Low byte on every lane
            end

            // Reserved codes
            default: begin
                size_mask = '0; // Nothing written
            end
        endcase
    end

    // No lane enabled while in reset or with we low
    assign wr_ok   = we && rst_n;
    assign lane_we = wr_ok ? size_mask : '0;

endmodule

//--- source/byte_bank.sv
`timescale 1ns/10ps

module byte_bank (
    input  logic                                clk_i,
    input  logic                                we,
    input  logic [dmem_pkg::word_addr_bits-1:0] idx,
    input  logic [7:0]                          wdata,
    output logic [7:0]                          rdata
);

    import dmem_pkg::*;

    // One byte lane of the data memory
    logic [7:0] mem [depth];

    // Start from all zeros in simulation
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // Write on the rising edge
    always @(posedge clk_i) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    // Asynchronous read at the same index
    // Same-cycle write to idx shows the old byte until the edge
    assign rdata = mem[idx];

endmodule

//--- source/load_extract.sv
`timescale 1ns/10ps

module load_extract (
    input  logic [dmem_pkg::lanes-1:0][7:0] lane_rdata,
    input  dmem_pkg::mem_width_e            width_src,
    input  logic [1:0]                      byte_off,
    output logic [dmem_pkg::xlen-1:0]       rdata
);

    import dmem_pkg::*;

    logic [xlen-1:0] word_val;  // All four lanes, lane 3 on top
    logic [15:0]     half_val;  // Lane pair picked by byte_off[1]
    logic [7:0]      byte_val;  // Lane picked by byte_off
    logic            half_fill; // Extension bit for half-word loads
    logic            byte_fill; // Extension bit for byte loads
    logic            is_signed; // Signed load codes

    // Word view of the banks
    assign word_val = lane_rdata;

    // Half-word field, addr[0] ignored
    always_comb begin
        if (byte_off[1]) begin
            half_val = {lane_rdata[3], lane_rdata[2]}; // Upper half
        end else begin
            half_val = {lane_rdata[1], lane_rdata[0]}; // Lower half
        end
    end

    // Byte field
    always_comb begin
        case (byte_off)
            2'b00:   byte_val = lane_rdata[0];
            2'b01:   byte_val = lane_rdata[1];
            2'b10:   byte_val = lane_rdata[2];
            default: byte_val = lane_rdata[3];
        endcase
    end

    // Bit 2 of the code selects zero fill
    assign is_signed = ~width_src[2];

    // Sign bit copied up only for signed codes
    assign half_fill = is_signed & half_val[15];
    assign byte_fill = is_signed & byte_val[7];

    // Final result per code
    always_comb begin
        case (width_src)
            width_word: begin
                rdata = word_val;
            end

            // lh / lhu
            width_half,
            width_half_u: begin
                rdata = {{16{half_fill}}, half_val};
            end

            // lb / lbu
            width_byte,
            width_byte_u: begin
                rdata = {{24{byte_fill}}, byte_val};
            end

            // Reserved codes read as zero
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

//--- source/data_mem.sv
`timescale 1ns/10ps

module data_mem (
    input  logic                      clk_i,
    input  logic                      rst_n,
    input  logic                      we,
    input  dmem_pkg::mem_width_e      width_src,
    input  logic [dmem_pkg::xlen-1:0] addr,
    input  logic [dmem_pkg::xlen-1:0] wdata,
    output logic [dmem_pkg::xlen-1:0] rdata
);

    import dmem_pkg::*;

    logic [lanes-1:0]          lane_we;    // Per-lane write strobes
    logic [lanes-1:0][7:0]     lane_wdata; // Lane-aligned store data
    logic [lanes-1:0][7:0]     lane_rdata; // Raw bank outputs
    logic [word_addr_bits-1:0] word_idx;   // Shared row index

    // Store side, size decode and lane steering
    store_align store_align_i (
        .we         (we),
        .width_src  (width_src),
        .addr       (addr),
        .wdata      (wdata),
        .rst_n      (rst_n),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .word_idx   (word_idx)
    );

    // Four byte lanes, lane n holds bits 8n+7:8n of each word
    for (genvar g = 0; g < lanes; g++) begin : gen_bank
        byte_bank byte_bank_i (
            .clk_i (clk_i),
            .we    (lane_we[g]),
            .idx   (word_idx),
            .wdata (lane_wdata[g]),
            .rdata (lane_rdata[g])
        );
    end

    // Load side, field select and extension
    load_extract load_extract_i (
        .lane_rdata (lane_rdata),
        .width_src  (width_src),
        .byte_off   (addr[1:0]),
        .rdata      (rdata)
    );

endmodule

//--- testbench/data_mem_props.sv
`timescale 1ns/10ps

module data_mem_props (
    input logic                      clk_i,
    input logic                      rst_n,
    input logic                      we,
    input dmem_pkg::mem_width_e      width_src,
    input logic [dmem_pkg::xlen-1:0] addr,
    input logic [dmem_pkg::xlen-1:0] wdata,
    input logic [dmem_pkg::xlen-1:0] rdata
);

    import dmem_pkg::*;

    int err_count = 0; // Failed checks so far

    logic [xlen-1:0]           shadow [depth]; // Reference copy of the memory
    logic [word_addr_bits-1:0] row;            // Word selected by addr[9:2]
    logic [xlen-1:0]           cur_word;       // Shadow word at row
    logic [xlen-1:0]           wr_mask;        // Bits a store replaces
    logic [xlen-1:0]           wr_data;        // Store data shifted into place
    logic [xlen-1:0]           byte_field;     // Addressed byte moved to bit 0
    logic [xlen-1:0]           half_field;     // Addressed half moved to bit 0
    logic [xlen-1:0]           exp_rdata;      // Expected load result
    logic                      is_reserved;    // Code outside the five valid ones
    logic                      is_narrow;      // Byte or half-word code

    // Upper address bits dropped, so aliases land on the same row
    assign row      = addr[word_addr_bits+1:2];
    assign cur_word = shadow[row];

    initial begin
        for (int i = 0; i < depth; i++) begin
            shadow[i] = '0; // Memory powers up cleared
        end
    end

    // Store rule expressed as a bit mask over the whole word
    always_comb begin
        wr_mask = '0;
        wr_data = '0;
        case (width_src)
            width_word: begin
                wr_mask = '1;
                wr_data = wdata;
            end
            width_half,
            width_half_u: begin
                wr_mask = 32'h0000_ffff << {addr[1], 4'b0000};           // addr[0] unused
                wr_data = {16'h0000, wdata[15:0]} << {addr[1], 4'b0000};
            end
            width_byte,
            width_byte_u: begin
                wr_mask = 32'h0000_00ff << {addr[1:0], 3'b000};
                wr_data = {24'h00_0000, wdata[7:0]} << {addr[1:0], 3'b000};
            end
            default: begin
                wr_mask = '0; // Reserved, no bits change
            end
        endcase
    end

    // Shadow follows the write edge, gated like the DUT
    always @(posedge clk_i) begin
        if (we && rst_n) begin
            shadow[row] <= (cur_word & ~wr_mask) | (wr_data & wr_mask);
        end
    end

    // Load rule, field shifted down then extended
    assign byte_field = cur_word >> {addr[1:0], 3'b000};
    assign half_field = cur_word >> {addr[1], 4'b0000};

    always_comb begin
        case (width_src)
            width_word:   exp_rdata = cur_word;
            width_half:   exp_rdata = {{16{half_field[15]}}, half_field[15:0]};
            width_half_u: exp_rdata = {16'h0000, half_field[15:0]};
            width_byte:   exp_rdata = {{24{byte_field[7]}}, byte_field[7:0]};
            width_byte_u: exp_rdata = {24'h00_0000, byte_field[7:0]};
            default:      exp_rdata = '0;
        endcase
    end

    assign is_reserved = !(width_src inside {width_word, width_half, width_half_u,
                                             width_byte, width_byte_u});
    assign is_narrow   = !is_reserved && (width_src != width_word);

    // Full word reads
    word_load_a: assert property (@(posedge clk_i)
        (width_src == width_word) |-> (rdata == exp_rdata))
        else begin
            err_count++;
            $error("mismatch at %0t: word load at %08h expected %08h, got %08h",
                   $time, $sampled(addr), $sampled(exp_rdata), $sampled(rdata));
        end

    // Byte and half-word reads, sign or zero fill
    narrow_load_a: assert property (@(posedge clk_i)
        is_narrow |-> (rdata == exp_rdata))
        else begin
            err_count++;
            $error("mismatch at %0t: code %03b at %08h expected %08h, got %08h",
                   $time, $sampled(width_src), $sampled(addr),
                   $sampled(exp_rdata), $sampled(rdata));
        end

    // Reserved codes read zero
    reserved_load_a: assert property (@(posedge clk_i)
        is_reserved |-> (rdata == '0))
        else begin
            err_count++;
            $error("mismatch at %0t: reserved code %03b expected 00000000, got %08h",
                   $time, $sampled(width_src), $sampled(rdata));
        end

    known_rdata_a: assert property (@(posedge clk_i) !$isunknown(rdata))
        else begin
            err_count++;
            $error("read data holds X or Z bits at %0t", $time);
        end

endmodule

// Checker rides along inside every data_mem
bind data_mem data_mem_props data_mem_props_i (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .we        (we),
    .width_src (width_src),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata)
);

//--- testbench/data_mem_tb.sv
`timescale 1ns/10ps

module data_mem_tb;

    import dmem_pkg::*;

    // Stimulus is about 700 cycles, limit is roughly three times that
    localparam int max_cycles = 2000;

    logic            clk_i = 1'b0;
    logic            rst_n;
    logic            we;
    mem_width_e      width_src;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] rdata;

    integer seed = 32'h0a7f6a5d; // Fixed seed for $random
    int     cycle_count = 0;
    int     timeout_errors = 0;

    data_mem data_mem_i (
        .clk_i     (clk_i),
        .rst_n     (rst_n),
        .we        (we),
        .width_src (width_src),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata)
    );

    always #4 clk_i = ~clk_i; // 8 ns period

    // Store for one cycle, inputs change on the falling edge
    task automatic store_op(input mem_width_e code, input logic [31:0] a,
                            input logic [31:0] d);
        @(negedge clk_i);
        we        = 1'b1;
        width_src = code;
        addr      = a;
        wdata     = d;
    endtask

    // Read for one cycle, wdata is noise with we low
    task automatic load_op(input mem_width_e code, input logic [31:0] a);
        @(negedge clk_i);
        we        = 1'b0;
        width_src = code;
        addr      = a;
        wdata     = $random(seed);
    endtask

    // Reset for two cycles with a word store attempted under it
    task automatic reset_pulse(input logic [31:0] a, input logic [31:0] d);
        @(negedge clk_i);
        rst_n     = 1'b0;
        we        = 1'b1;
        width_src = width_word;
        addr      = a;
        wdata     = d;
        @(negedge clk_i);
        @(negedge clk_i);
        rst_n     = 1'b1;
        we        = 1'b0;
    endtask

    // Closing line with counts, then the status
    task automatic finish_run();
        int assert_errors;
        int total;
        assert_errors = data_mem_i.data_mem_props_i.err_count;
        total         = assert_errors + timeout_errors;
        $display("errors: %0d assertion, %0d timeout, %0d total",
                 assert_errors, timeout_errors, total);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // Watchdog
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            timeout_errors = 1;
            finish_run();
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] a_alt;
        logic [31:0] d;
        logic [31:0] r;
        mem_width_e  rsvd_codes [3];

        rsvd_codes[0] = mem_width_e'(3'b011);
        rsvd_codes[1] = mem_width_e'(3'b100);
        rsvd_codes[2] = mem_width_e'(3'b111);

        rst_n     = 1'b0;
        we        = 1'b0;
        width_src = width_word;
        addr      = '0;
        wdata     = '0;

        // Reset, second cycle tries a store that must be blocked
        @(negedge clk_i);
        we    = 1'b1;
        addr  = 32'h0000_0010;
        wdata = 32'hdead_beef;
        @(negedge clk_i);
        rst_n = 1'b1;
        we    = 1'b0;
        load_op(width_word, 32'h0000_0010); // Still zero

        // Word round trip
        for (int i = 0; i < 100; i++) begin
            a      = $random(seed);
            a[1:0] = 2'b00;
            d      = $random(seed);
            store_op(width_word, a, d);
            load_op(width_word, a);
        end

        // Byte stores on each lane, signed and unsigned codes alike
        for (int i = 0; i < 8; i++) begin
            a      = $random(seed);
            a[1:0] = 2'b00;
            store_op(width_word, a, $random(seed));
            for (int b = 0; b < 4; b++) begin
                store_op((b % 2 == 0) ? width_byte : width_byte_u, a + b, $random(seed));
                load_op(width_word, a); // Other three bytes intact
            end
        end

        // Half-word stores, low half then high half, addr[0] random
        for (int i = 0; i < 8; i++) begin
            a      = $random(seed);
            a[1:0] = 2'b00;
            r      = $random(seed);
            store_op(width_word, a, $random(seed));
            store_op(width_half, {a[31:2], 1'b0, r[0]}, $random(seed));
            load_op(width_word, a);
            store_op(width_half_u, {a[31:2], 1'b1, r[1]}, $random(seed));
            load_op(width_word, a);
        end

        // Narrow loads, mostly with the top bit of each byte set
        for (int i = 0; i < 16; i++) begin
            a      = $random(seed);
            a[1:0] = 2'b00;
            d      = $random(seed) | 32'h8080_8080;
            if (i % 4 == 3) begin
                d = d & 32'h7f7f_7f7f; // Some positive values too
            end
            store_op(width_word, a, d);
            for (int b = 0; b < 4; b++) begin
                load_op(width_byte, a + b);
                load_op(width_byte_u, a + b);
            end
            for (int h = 0; h < 2; h++) begin
                load_op(width_half, a + 2 * h);
                load_op(width_half_u, a + 2 * h + (i % 2));
            end
        end

        // Reserved codes store nothing and read zero
        for (int i = 0; i < 18; i++) begin
            a      = $random(seed);
            a[1:0] = 2'b00;
            store_op(width_word, a, $random(seed));
            store_op(rsvd_codes[i % 3], a + (i % 4), $random(seed));
            load_op(rsvd_codes[(i + 1) % 3], a);
            load_op(width_word, a);
        end

        // we low with live data never writes
        for (int i = 0; i < 16; i++) begin
            a = $random(seed);
            load_op(width_word, a);
            load_op(width_word, a);
        end

        // Store attempted during a mid-run reset
        a = 32'h0000_0200;
        store_op(width_word, a, 32'h1234_5678);
        reset_pulse(a, 32'hcafe_f00d);
        load_op(width_word, a);

        // Address wrap, only bits above 9 differ
        for (int i = 0; i < 32; i++) begin
            a      = $random(seed);
            a[1:0] = 2'b00;
            r      = $random(seed);
            a_alt  = {r[31:10], a[9:0]};
            store_op(width_word, a, $random(seed));
            load_op(width_word, a_alt);
        end

        // Let the last checks fire
        load_op(width_word, 32'h0);
        @(negedge clk_i);
        @(negedge clk_i);
        finish_run();
    end

endmodule

//--- sim.f
source/dmem_pkg.sv
source/store_align.sv
source/byte_bank.sv
source/load_extract.sv
source/data_mem.sv
testbench/data_mem_props.sv
testbench/data_mem_tb.sv

//--- Makefile
# Verilator simulation of the data memory
# Override any variable on the command line, e.g. make simulate LOG=run.log

VERILATOR ?= verilator
TOP       ?= data_mem_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100000
PASS_MSG  ?= STATUS: PASS

.PHONY: simulate clean

# Build, run, then decide the result from the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
